/* logic/pit_pkg.sv */
// Interval timer shared widths, control-word layout and bus/load bundles
package pit_pkg;

	// Widths with a meaning of their own
	typedef logic [7:0]  byte_t;
	typedef logic [15:0] count_t;
	typedef logic [1:0]  chan_sel_t;
	typedef logic [1:0]  addr_t;

	// Read/write format, control word bits 5:4
	typedef enum logic [1:0] {
		ACC_LATCH = 2'd0,
		ACC_LSB   = 2'd1,
		ACC_MSB   = 2'd2,
		ACC_WORD  = 2'd3
	} access_e;

	// Only two modes count, any other stored value parks the channel
	typedef enum logic [2:0] {
		MODE_TERMINAL = 3'd0,
		MODE_SQUARE   = 3'd3
	} mode_e;

	// Control word as it appears on the data bus
	typedef struct packed {
		chan_sel_t sel;
		access_e   access;
		mode_e     mode;
		logic      bcd;
	} ctrl_word_t;

	// Decoder to channel, one per channel
	typedef struct packed {
		logic  wr_cnt;
		logic  rd_cnt;
		logic  wr_ctrl;
		byte_t cmd;
	} bus_req_t;

	// Channel control to down counter
	typedef struct packed {
		logic   arm;
		// Pulse on a new control word, halts counting until the next arm
		logic   stop;
		count_t value;
		mode_e  mode;
	} load_t;

	localparam int NUM_CHANNELS = 3;

	// Loaded when software writes a count of zero
	localparam count_t FULL_COUNT = 16'hFFFF;

endpackage

/* logic/pit_bus_decode.sv */
// Bus decoder for the timer, routes strobes per channel and registers read data
`timescale 1ns/1ps

module pit_bus_decode (
	input  logic             ZCLK,
	input  logic             rst_n,
	input  logic             cs_n,
	input  logic             rd_n,
	input  logic             wr_n,
	input  pit_pkg::addr_t   addr,
	input  pit_pkg::byte_t   data_in,
	output pit_pkg::bus_req_t req [pit_pkg::NUM_CHANNELS],
	input  pit_pkg::byte_t   rd_data [pit_pkg::NUM_CHANNELS],
	output pit_pkg::byte_t   data_out,
	output logic             data_oe
);

	import pit_pkg::*;

	localparam addr_t ADDR_CTRL = 2'd3;

	logic                    rd_stb;
	logic                    wr_stb;
	ctrl_word_t              cw;
	logic [NUM_CHANNELS-1:0] active;

	// A cycle with both strobes low is treated as no access
	assign rd_stb = !cs_n && !rd_n && wr_n;
	assign wr_stb = !cs_n && !wr_n && rd_n;
	assign cw     = ctrl_word_t'(data_in);

	for (genvar i = 0; i < NUM_CHANNELS; i++) begin : g_req
		assign req[i] = '{
			wr_cnt:  wr_stb && (addr == addr_t'(i)),
			rd_cnt:  rd_stb && (addr == addr_t'(i)),
			// Control words go by their own channel field, sel of 3 reaches nobody
			wr_ctrl: wr_stb && (addr == ADDR_CTRL) && (cw.sel == chan_sel_t'(i)),
			cmd:     data_in
		};
		assign active[i] = req[i].wr_cnt || req[i].rd_cnt || req[i].wr_ctrl;
	end

	// Read byte captured on the strobe, valid the next cycle
	always_ff @(posedge ZCLK) begin
		if (rd_stb && addr != ADDR_CTRL) begin
			data_out <= rd_data[addr];
		end
	end

	// Drive the bus from the cycle after a read until the next access
	always_ff @(posedge ZCLK or negedge rst_n) begin
		if (!rst_n) begin
			data_oe <= 1'b0;
		end else if (rd_stb && addr != ADDR_CTRL) begin
			data_oe <= 1'b1;
		end else if (rd_stb || wr_stb) begin
			data_oe <= 1'b0;
		end
	end

	a_one_channel: assert property (@(posedge ZCLK) disable iff (!rst_n) $onehot0(active))
		else $error("more than one channel addressed in one cycle");

endmodule

/* logic/pit_channel_ctrl.sv */
// Channel control, holds the mode register, sequences count writes and latched reads
`timescale 1ns/1ps

module pit_channel_ctrl (
	input  logic              ZCLK,
	input  logic              rst_n,
	input  pit_pkg::bus_req_t req,
	input  pit_pkg::count_t   count,
	output pit_pkg::load_t    load,
	output pit_pkg::byte_t    rd_data
);

	import pit_pkg::*;

	// W_IDLE until the first control word gives a write format
	typedef enum logic [1:0] {
		W_IDLE = 2'd0,
		W_LSB  = 2'd1,
		W_MSB  = 2'd2
	} w_state_e;

	w_state_e   wr_state;
	ctrl_word_t ctrl_q;
	ctrl_word_t cw;
	logic       arm_q;
	logic       stop_q;
	logic       rd_msb_q;
	logic       write_done;
	byte_t      lsb_q;
	count_t     new_value;
	count_t     value_q;
	count_t     latch_q;

	function automatic count_t fill_zero(count_t v);
		return (v == '0) ? FULL_COUNT : v;
	endfunction

	assign cw = ctrl_word_t'(req.cmd);

	// Last byte of the programmed format
	assign write_done = req.wr_cnt &&
		(wr_state == W_MSB || (wr_state == W_LSB && ctrl_q.access != ACC_WORD));

	// Missing half of a single-byte write reads as zero
	always_comb begin
		if (wr_state == W_LSB) begin
			new_value = {8'h00, req.cmd};
		end else begin
			new_value = {req.cmd, (ctrl_q.access == ACC_WORD) ? lsb_q : 8'h00};
		end
	end

	always_ff @(posedge ZCLK or negedge rst_n) begin
		if (!rst_n) begin
			ctrl_q   <= '0;
			wr_state <= W_IDLE;
			arm_q    <= 1'b0;
			stop_q   <= 1'b0;
			rd_msb_q <= 1'b0;
		end else begin
			arm_q  <= write_done;
			stop_q <= 1'b0;
			if (req.wr_ctrl) begin
				rd_msb_q <= 1'b0;
				// Access 00 is the latch command and leaves the mode alone
				if (cw.access != ACC_LATCH) begin
					ctrl_q   <= '{sel: '0, access: cw.access, mode: cw.mode, bcd: cw.bcd};
					stop_q   <= 1'b1;
					wr_state <= (cw.access == ACC_MSB) ? W_MSB : W_LSB;
				end
			end else if (req.wr_cnt) begin
				case (wr_state)
					W_LSB: begin
						if (ctrl_q.access == ACC_WORD) begin
							wr_state <= W_MSB;
						end
					end
					W_MSB: begin
						if (ctrl_q.access == ACC_WORD) begin
							wr_state <= W_LSB;
						end
					end
					default: begin
						wr_state <= W_IDLE;
					end
				endcase
			end else if (req.rd_cnt && ctrl_q.access == ACC_WORD) begin
				// Word reads alternate low byte then high byte
				rd_msb_q <= !rd_msb_q;
			end
		end
	end

	always_ff @(posedge ZCLK) begin
		if (req.wr_ctrl && cw.access == ACC_LATCH) begin
			latch_q <= count;
		end
		if (req.wr_cnt && wr_state == W_LSB) begin
			lsb_q <= req.cmd;
		end
		if (write_done) begin
			value_q <= fill_zero(new_value);
		end
	end

	always_comb begin
		if (ctrl_q.access == ACC_MSB || (ctrl_q.access == ACC_WORD && rd_msb_q)) begin
			rd_data = latch_q[15:8];
		end else begin
			rd_data = latch_q[7:0];
		end
	end

	assign load = '{arm: arm_q, stop: stop_q, value: value_q, mode: ctrl_q.mode};

	a_wr_state_legal: assert property (@(posedge ZCLK) disable iff (!rst_n)
		wr_state inside {W_IDLE, W_LSB, W_MSB})
		else $error("count write state out of range");

endmodule

/* logic/pit_down_counter.sv */
// Down counter for one channel, counter clock edge detect, reload and out generation
`timescale 1ns/1ps

module pit_down_counter #(
	parameter int unsigned SYNC_STAGES = 2
) (
	input  logic            ZCLK,
	input  logic            rst_n,
	input  pit_pkg::load_t  load,
	input  logic            cnt_clk,
	input  logic            gate,
	output pit_pkg::count_t count,
	output logic            out
);

	import pit_pkg::*;

	logic [SYNC_STAGES-1:0] sync_q;
	logic                   prev_q;
	logic                   tick;
	logic                   pending_q;
	logic                   pending_d;
	logic                   running_q;
	logic                   running_d;
	logic                   active_mode;
	logic                   out_d;
	count_t                 count_q;
	count_t                 count_d;
	count_t                 reload_q;
	count_t                 reload_d;

	// Counter clock brought into ZCLK, tick is a registered rising edge
	always_ff @(posedge ZCLK or negedge rst_n) begin
		if (!rst_n) begin
			sync_q <= '0;
			prev_q <= 1'b0;
			tick   <= 1'b0;
		end else begin
			sync_q <= {sync_q[SYNC_STAGES-2:0], cnt_clk};
			prev_q <= sync_q[SYNC_STAGES-1];
			tick   <= sync_q[SYNC_STAGES-1] && !prev_q;
		end
	end

	assign active_mode = (load.mode == MODE_TERMINAL) || (load.mode == MODE_SQUARE);

	always_comb begin
		count_d   = count_q;
		reload_d  = reload_q;
		pending_d = pending_q;
		running_d = running_q;
		if (load.stop) begin
			pending_d = 1'b0;
			running_d = 1'b0;
		end else if (load.arm) begin
			pending_d = 1'b1;
		end else if (tick && gate && active_mode) begin
			if (pending_q) begin
				// First tick after arm only loads
				count_d   = load.value;
				reload_d  = load.value;
				pending_d = 1'b0;
				running_d = 1'b1;
			end else if (running_q) begin
				if (load.mode == MODE_SQUARE) begin
					count_d = (count_q == 16'd1) ? reload_q : count_q - 16'd1;
				end else if (count_q != '0) begin
					count_d = count_q - 16'd1;
				end
			end
		end
	end

	always_comb begin
		case (load.mode)
			MODE_TERMINAL: begin
				out_d = out_q_hold();
			end
			MODE_SQUARE: begin
				// High for the upper half of the reload range
				out_d = !gate || !running_d || (count_d > (reload_d >> 1));
			end
			default: begin
				out_d = 1'b1;
			end
		endcase
	end

	// Terminal count holds out low from programming until count hits zero
	function automatic logic out_q_hold();
		if (load.stop || load.arm) begin
			return 1'b0;
		end else if (running_d && count_d == '0) begin
			return 1'b1;
		end
		return out;
	endfunction

	always_ff @(posedge ZCLK or negedge rst_n) begin
		if (!rst_n) begin
			count_q   <= '0;
			pending_q <= 1'b0;
			running_q <= 1'b0;
			out       <= 1'b1;
		end else begin
			count_q   <= count_d;
			pending_q <= pending_d;
			running_q <= running_d;
			out       <= out_d;
		end
	end

	always_ff @(posedge ZCLK) begin
		reload_q <= reload_d;
	end

	assign count = count_q;

	a_terminal_sticky: assert property (@(posedge ZCLK) disable iff (!rst_n)
		(load.mode == MODE_TERMINAL && out && !load.arm && !load.stop) |=> out)
		else $error("mode 0 out dropped without a new count");

endmodule

/* logic/pit_channel.sv */
// One timer channel, control and down counter joined by the load bundle
`timescale 1ns/1ps

module pit_channel #(
	parameter int unsigned SYNC_STAGES = 2
) (
	input  logic              ZCLK,
	input  logic              rst_n,
	input  pit_pkg::bus_req_t req,
	output pit_pkg::byte_t    rd_data,
	input  logic              cnt_clk,
	input  logic              gate,
	output logic              out
);

	import pit_pkg::*;

	load_t  load;
	count_t count;

	pit_channel_ctrl u_ctrl (
		.ZCLK    (ZCLK),
		.rst_n   (rst_n),
		.req     (req),
		.count   (count),
		.load    (load),
		.rd_data (rd_data)
	);

	// Live count returns to control for the latch command
	pit_down_counter #(
		.SYNC_STAGES (SYNC_STAGES)
	) u_counter (
		.ZCLK    (ZCLK),
		.rst_n   (rst_n),
		.load    (load),
		.cnt_clk (cnt_clk),
		.gate    (gate),
		.count   (count),
		.out     (out)
	);

endmodule

/* logic/pit_top.sv */
// Three-channel synchronous interval timer, bus decoder plus replicated channels
`timescale 1ns/1ps

module pit_top #(
	parameter int unsigned SYNC_STAGES = 2
) (
	input  logic                             ZCLK,
	input  logic                             rst_n,
	input  logic                             cs_n,
	input  logic                             rd_n,
	input  logic                             wr_n,
	input  pit_pkg::addr_t                   addr,
	input  pit_pkg::byte_t                   data_in,
	output pit_pkg::byte_t                   data_out,
	output logic                             data_oe,
	input  logic [pit_pkg::NUM_CHANNELS-1:0] cnt_clk,
	input  logic [pit_pkg::NUM_CHANNELS-1:0] gate,
	output logic [pit_pkg::NUM_CHANNELS-1:0] out
);

	import pit_pkg::*;

	bus_req_t req     [NUM_CHANNELS];
	byte_t    rd_data [NUM_CHANNELS];

	pit_bus_decode u_decode (
		.ZCLK     (ZCLK),
		.rst_n    (rst_n),
		.cs_n     (cs_n),
		.rd_n     (rd_n),
		.wr_n     (wr_n),
		.addr     (addr),
		.data_in  (data_in),
		.req      (req),
		.rd_data  (rd_data),
		.data_out (data_out),
		.data_oe  (data_oe)
	);

	for (genvar i = 0; i < NUM_CHANNELS; i++) begin : g_chan
		pit_channel #(
			.SYNC_STAGES (SYNC_STAGES)
		) u_chan (
			.ZCLK    (ZCLK),
			.rst_n   (rst_n),
			.req     (req[i]),
			.rd_data (rd_data[i]),
			.cnt_clk (cnt_clk[i]),
			.gate    (gate[i]),
			.out     (out[i])
		);
	end

endmodule

/* verif/pit_tb.sv */
// Table-driven testbench for the three-channel interval timer
`timescale 1ns/1ps

module pit_tb;

	import pit_pkg::*;

	localparam addr_t ADDR_CTRL   = 2'd3;
	localparam int    HOLD_PULSES = 3;
	localparam int    OE_TIMEOUT  = 10;

	typedef enum {K_OUT, K_READ, K_GATE} check_e;

	typedef struct {
		string   name;
		int      chan;
		mode_e   mode;
		access_e access;
		count_t  value;
		logic    gate;
		int      pulses;
		check_e  kind;
		count_t  expect_val;
	} row_t;

	logic                    ZCLK;
	logic                    rst_n;
	logic                    cs_n;
	logic                    rd_n;
	logic                    wr_n;
	addr_t                   addr;
	byte_t                   data_in;
	byte_t                   data_out;
	logic                    data_oe;
	logic [NUM_CHANNELS-1:0] cnt_clk;
	logic [NUM_CHANNELS-1:0] gate;
	logic [NUM_CHANNELS-1:0] out;
	row_t                    table_q [$];
	integer                  seed;
	int                      error_count;

	pit_top #(.SYNC_STAGES(2)) uut (
		.ZCLK(ZCLK), .rst_n(rst_n), .cs_n(cs_n), .rd_n(rd_n), .wr_n(wr_n),
		.addr(addr), .data_in(data_in), .data_out(data_out), .data_oe(data_oe),
		.cnt_clk(cnt_clk), .gate(gate), .out(out)
	);

	initial ZCLK = 1'b0;
	always #2 ZCLK = ~ZCLK;

	task automatic report_failure();
		$display("Test FAILED");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic compare_out(string name, logic expected, logic actual);
		if (actual !== expected) begin
			error_count++;
			$display("MISMATCH %s expected %0b actual %0b", name, expected, actual);
			report_failure();
		end
	endtask

	task automatic compare_count(string name, count_t expected, count_t actual);
		if (actual !== expected) begin
			error_count++;
			$display("MISMATCH %s expected %04h actual %04h", name, expected, actual);
			report_failure();
		end
	endtask

	// One strobe cycle, then one idle cycle
	task automatic bus_write(addr_t a, byte_t d);
		@(negedge ZCLK);
		cs_n    = 1'b0;
		wr_n    = 1'b0;
		addr    = a;
		data_in = d;
		@(negedge ZCLK);
		cs_n = 1'b1;
		wr_n = 1'b1;
	endtask

	task automatic bus_read(addr_t a, output byte_t d);
		int waited;
		@(negedge ZCLK);
		cs_n = 1'b0;
		rd_n = 1'b0;
		addr = a;
		@(negedge ZCLK);
		cs_n   = 1'b1;
		rd_n   = 1'b1;
		waited = 0;
		while (!data_oe && waited < OE_TIMEOUT) begin
			@(negedge ZCLK);
			waited++;
		end
		if (!data_oe) begin
			$display("Timeout: data_oe never went high after a read of address %0d", a);
			report_failure();
		end
		d = data_out;
	endtask

	task automatic program_channel(int chan, mode_e mode, access_e acc, count_t value);
		ctrl_word_t cw;
		cw = '{sel: chan_sel_t'(chan), access: acc, mode: mode, bcd: 1'b0};
		bus_write(ADDR_CTRL, byte_t'(cw));
		// Single-byte formats send the low byte of value
		bus_write(addr_t'(chan), value[7:0]);
		if (acc == ACC_WORD) begin
			bus_write(addr_t'(chan), value[15:8]);
		end
	endtask

	task automatic latch_read(int chan, access_e acc, output count_t c);
		ctrl_word_t cw;
		byte_t      lo;
		byte_t      hi;
		cw = '{sel: chan_sel_t'(chan), access: ACC_LATCH, mode: MODE_TERMINAL, bcd: 1'b0};
		lo = '0;
		hi = '0;
		bus_write(ADDR_CTRL, byte_t'(cw));
		if (acc == ACC_WORD) begin
			bus_read(addr_t'(chan), lo);
			bus_read(addr_t'(chan), hi);
		end else if (acc == ACC_MSB) begin
			bus_read(addr_t'(chan), hi);
		end else begin
			bus_read(addr_t'(chan), lo);
		end
		c = {hi, lo};
	endtask

	// 8 cycles high, 8 low, so out has settled on return
	task automatic pulse_clk(int chan);
		@(negedge ZCLK);
		cnt_clk[chan] = 1'b1;
		repeat (8) @(negedge ZCLK);
		cnt_clk[chan] = 1'b0;
		repeat (8) @(negedge ZCLK);
	endtask

	// Out level after p counter pulses where the first pulse loads
	function automatic logic expected_out(mode_e mode, count_t value, int p);
		int v;
		v = int'(value);
		if (mode == MODE_TERMINAL) begin
			return p > v;
		end
		if (p == 0) begin
			return 1'b1;
		end
		// Square wave period of v pulses, the first ceil(v/2) of them high
		return ((p - 1) % v) < ((v + 1) / 2);
	endfunction

	task automatic add_row(string name, int chan, mode_e mode, access_e acc, count_t value,
			logic g, int pulses, check_e kind, count_t expect_val);
		row_t r;
		r.name       = name;
		r.chan       = chan;
		r.mode       = mode;
		r.access     = acc;
		r.value      = value;
		r.gate       = g;
		r.pulses     = pulses;
		r.kind       = kind;
		r.expect_val = expect_val;
		table_q.push_back(r);
	endtask

	task automatic run_row(row_t r);
		count_t got;
		count_t held;
		@(negedge ZCLK);
		gate[r.chan] = (r.kind == K_GATE) ? 1'b1 : r.gate;
		program_channel(r.chan, r.mode, r.access, r.value);
		if (r.kind == K_OUT) begin
			compare_out({r.name, "/p0"}, expected_out(r.mode, r.value, 0), out[r.chan]);
			for (int p = 1; p <= r.pulses; p++) begin
				pulse_clk(r.chan);
				compare_out($sformatf("%s/p%0d", r.name, p),
					expected_out(r.mode, r.value, p), out[r.chan]);
			end
			compare_out({r.name, "/end"}, r.expect_val[0], out[r.chan]);
		end else begin
			for (int p = 1; p <= r.pulses; p++) begin
				pulse_clk(r.chan);
			end
			latch_read(r.chan, r.access, got);
			compare_count(r.name, r.expect_val, got);
			if (r.kind == K_GATE) begin
				@(negedge ZCLK);
				gate[r.chan] = r.gate;
				for (int p = 1; p <= HOLD_PULSES; p++) begin
					pulse_clk(r.chan);
					compare_out($sformatf("%s/gated%0d", r.name, p), 1'b1, out[r.chan]);
				end
				latch_read(r.chan, r.access, held);
				compare_count({r.name, "/held"}, got, held);
				@(negedge ZCLK);
				gate[r.chan] = 1'b1;
			end
		end
	endtask

	initial begin
		int rnd;
		int v;
		int k;
		seed        = 32'ha0c6_fa16;
		error_count = 0;
		rst_n       = 1'b0;
		cs_n        = 1'b1;
		rd_n        = 1'b1;
		wr_n        = 1'b1;
		addr        = '0;
		data_in     = '0;
		cnt_clk     = '0;
		gate        = '1;
		repeat (8) @(negedge ZCLK);
		rst_n = 1'b1;
		repeat (2) @(negedge ZCLK);
		for (int i = 0; i < NUM_CHANNELS; i++) begin
			compare_out($sformatf("reset_out%0d", i), 1'b1, out[i]);
		end
		compare_out("reset_oe", 1'b0, data_oe);

		add_row("m0_ch0_word", 0, MODE_TERMINAL, ACC_WORD, 16'd5, 1'b1, 8, K_OUT, 16'd1);
		add_row("m0_ch1_word", 1, MODE_TERMINAL, ACC_WORD, 16'd3, 1'b1, 6, K_OUT, 16'd1);
		add_row("m0_ch2_word", 2, MODE_TERMINAL, ACC_WORD, 16'd7, 1'b1, 10, K_OUT, 16'd1);
		add_row("m3_even", 0, MODE_SQUARE, ACC_WORD, 16'd6, 1'b1, 12, K_OUT, 16'd0);
		add_row("m3_odd", 1, MODE_SQUARE, ACC_WORD, 16'd5, 1'b1, 10, K_OUT, 16'd0);
		add_row("latch_word", 2, MODE_TERMINAL, ACC_WORD, 16'd300, 1'b1, 4, K_READ, 16'd297);
		add_row("lsb_only", 0, MODE_TERMINAL, ACC_LSB, 16'h005A, 1'b1, 1, K_READ, 16'h005A);
		add_row("msb_only", 1, MODE_TERMINAL, ACC_MSB, 16'h0003, 1'b1, 1, K_READ, 16'h0300);
		// Gated while in the low half so the forced high level shows
		add_row("gate_hold", 2, MODE_SQUARE, ACC_WORD, 16'd10, 1'b0, 7, K_GATE, 16'd4);

		// Random counts from 2 to 40
		rnd = $random(seed);
		v   = 2 + ((rnd & 32'h7fff_ffff) % 39);
		rnd = $random(seed);
		k   = 1 + ((rnd & 32'h7fff_ffff) % v);
		add_row("rand_latch", 0, MODE_TERMINAL, ACC_WORD, count_t'(v), 1'b1, k, K_READ,
			count_t'(v - (k - 1)));
		rnd = $random(seed);
		v   = 2 + ((rnd & 32'h7fff_ffff) % 39);
		add_row("rand_square", 1, MODE_SQUARE, ACC_WORD, count_t'(v), 1'b1, 2 * v, K_OUT,
			count_t'(expected_out(MODE_SQUARE, count_t'(v), 2 * v)));

		foreach (table_q[i]) begin
			run_row(table_q[i]);
		end

		if (error_count == 0) begin
			$display("Test OK");
			$finish;
		end else begin
			$display("%0d checks did not match", error_count);
			report_failure();
		end
	end

endmodule

/* all.f */
logic/pit_pkg.sv
logic/pit_bus_decode.sv
logic/pit_channel_ctrl.sv
logic/pit_down_counter.sv
logic/pit_channel.sv
logic/pit_top.sv
verif/pit_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the interval timer testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module pit_tb \
	-o pit_sim > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
	cat "$BUILD_LOG"
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/pit_sim > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Test FAILED" "$SIM_LOG"; then
	exit 1
fi
exit 0
